/* core_mem.f */
rtl/core_pkg.sv
rtl/data_mem.sv
rtl/cp0_regs.sv
rtl/core_mem_stage.sv
sim/core_mem_properties.sv
sim/tb_core_mem.sv

/* sim/tb_core_mem.sv */
`timescale 1ns/1ns

module tb_core_mem;
    import core_pkg::*;

    localparam int mem_bytes     = 4096;
    localparam int region_bytes  = 256;  // Address window used by the tests
    localparam int planned_items = 200;
    localparam int timeout_ns    = (planned_items + 50) * 20;

    logic       clock;
    logic       reset;
    dword_t     alu_out;
    dword_t     b_data;
    mem_size_t  load_size;
    mem_size_t  store_size;
    logic       load_signed;
    regnum_t    w_regnum;
    logic       write_enable;
    logic       mfc0;
    logic       mtc0;
    cp0_num_t   cp0_num;
    logic       link_pc;
    dword_t     pc;
    dword_t     pc4;
    logic       overflow;
    logic       reserved_inst;
    logic       syscall;
    logic       eret;
    logic       flush;
    dword_t     fetch_pc;
    irq_t       irq;
    logic       d_valid;
    dword_t     d_rdata;
    word_t      inst;
    dword_t     w_data_q;
    regnum_t    w_regnum_q;
    logic       write_enable_q;
    dword_t     epc_q;
    logic       taken_handler_q;

    // Expected results of the item being driven
    dword_t     exp_w_data;
    logic       chk_w_data;
    logic       exp_taken;
    dword_t     exp_epc;
    logic       chk_epc;
    word_t      exp_inst;
    logic       chk_inst;

    // Lined up with the stage output register
    dword_t     exp_w_data_q;
    logic       chk_w_data_q;
    regnum_t    exp_regnum_q;
    logic       exp_we_q;
    logic       exp_taken_q;
    dword_t     exp_epc_q;
    logic       chk_epc_q;

    logic [7:0] shadow [region_bytes];
    logic       mem_filled;
    integer     seed;
    int         errors = 0;

    core_mem_stage #(
        .mem_bytes(mem_bytes)
    ) core_mem_stage_i (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout after %0d ns, the test sequence never finished", timeout_ns);
        $display("Errors: %0d in checks, %0d in bound properties", errors,
                 core_mem_stage_i.core_mem_properties_i.failures);
        $display("Simulation FAILED");
        $finish;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            exp_w_data_q <= '0;
            chk_w_data_q <= 1'b0;
            exp_regnum_q <= '0;
            exp_we_q     <= 1'b0;
            exp_taken_q  <= 1'b0;
            exp_epc_q    <= '0;
            chk_epc_q    <= 1'b0;
        end else begin
            exp_w_data_q <= exp_w_data;
            chk_w_data_q <= chk_w_data;
            exp_regnum_q <= w_regnum;
            exp_we_q     <= write_enable;
            exp_taken_q  <= exp_taken;
            exp_epc_q    <= exp_epc;
            chk_epc_q    <= chk_epc;
        end
    end

    w_data_check: assert property (
        @(posedge clock) disable iff (reset) chk_w_data_q |-> w_data_q == exp_w_data_q
    ) else begin
        errors++;
        $display("[FAIL] w_data_q got %h expected %h", $sampled(w_data_q), $sampled(exp_w_data_q));
    end

    w_regnum_check: assert property (
        @(posedge clock) disable iff (reset) w_regnum_q == exp_regnum_q
    ) else begin
        errors++;
        $display("[FAIL] w_regnum_q got %h expected %h", $sampled(w_regnum_q),
                 $sampled(exp_regnum_q));
    end

    write_enable_check: assert property (
        @(posedge clock) disable iff (reset) write_enable_q == exp_we_q
    ) else begin
        errors++;
        $display("[FAIL] write_enable_q got %h expected %h", $sampled(write_enable_q),
                 $sampled(exp_we_q));
    end

    taken_check: assert property (
        @(posedge clock) disable iff (reset) taken_handler_q == exp_taken_q
    ) else begin
        errors++;
        $display("[FAIL] taken_handler_q got %h expected %h", $sampled(taken_handler_q),
                 $sampled(exp_taken_q));
    end

    epc_check: assert property (
        @(posedge clock) disable iff (reset) chk_epc_q |-> epc_q == exp_epc_q
    ) else begin
        errors++;
        $display("[FAIL] epc_q got %h expected %h", $sampled(epc_q), $sampled(exp_epc_q));
    end

    inst_check: assert property (
        @(posedge clock) disable iff (reset) chk_inst |-> inst == exp_inst
    ) else begin
        errors++;
        $display("[FAIL] inst got %h expected %h", $sampled(inst), $sampled(exp_inst));
    end

    function automatic int size_bytes(mem_size_t size);
        case (size)
            SIZE_BYTE:  return 1;
            SIZE_HALF:  return 2;
            SIZE_WORD:  return 4;
            SIZE_DWORD: return 8;
            default:    return 0;
        endcase
    endfunction

    // First byte of the access, aligned down to its size
    function automatic int lane_base(dword_t addr, mem_size_t size);
        return int'(addr[7:0]) & ~(size_bytes(size) - 1);
    endfunction

    function automatic dword_t expect_load(dword_t addr, mem_size_t size, logic sign);
        int     n;
        int     base;
        dword_t value;
        n = size_bytes(size);
        base = lane_base(addr, size);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[8*i +: 8] = shadow[base + i];
        end
        if (sign) begin
            for (int j = 8 * n; j < 64; j++) begin
                value[j] = value[8*n - 1];
            end
        end
        return value;
    endfunction

    function automatic void store_shadow(dword_t addr, dword_t data, mem_size_t size);
        int base;
        base = lane_base(addr, size);
        for (int i = 0; i < size_bytes(size); i++) begin
            shadow[base + i] = data[8*i +: 8];
        end
    endfunction

    function automatic word_t shadow_word(dword_t addr);
        int base;
        base = int'(addr[7:0]) & ~3;
        return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
    endfunction

    function automatic dword_t rand_dword();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic dword_t rand_addr();
        return 64'($random(seed) & (region_bytes - 1));
    endfunction

    // Idle item with random register fields and fetch address
    function automatic void idle_inputs();
        alu_out       = '0;
        b_data        = '0;
        load_size     = SIZE_NONE;
        store_size    = SIZE_NONE;
        load_signed   = 1'b0;
        w_regnum      = 5'($random(seed));
        write_enable  = 1'($random(seed));
        mfc0          = 1'b0;
        mtc0          = 1'b0;
        cp0_num       = '0;
        link_pc       = 1'b0;
        pc            = '0;
        pc4           = '0;
        overflow      = 1'b0;
        reserved_inst = 1'b0;
        syscall       = 1'b0;
        eret          = 1'b0;
        flush         = 1'b0;
        irq           = '0;
        d_valid       = 1'b0;
        d_rdata       = rand_dword();
        fetch_pc      = rand_addr();
        exp_w_data    = '0;
        chk_w_data    = 1'b0;
        exp_taken     = 1'b0;
        exp_epc       = '0;
        chk_epc       = 1'b0;
        exp_inst      = shadow_word(fetch_pc);
        chk_inst      = mem_filled;
    endfunction

    function automatic void expect_data(dword_t value);
        exp_w_data = value;
        chk_w_data = 1'b1;
    endfunction

    task automatic next_item();
        @(negedge clock);
        idle_inputs();
    endtask

    task automatic store_item(dword_t addr, dword_t data, mem_size_t size, logic squash,
                              logic mmio);
        next_item();
        alu_out    = addr;
        b_data     = data;
        store_size = size;
        flush      = squash;
        d_valid    = mmio;
        expect_data(addr);
        if (!squash && !mmio) begin
            store_shadow(addr, data, size);
        end
    endtask

    task automatic load_item(dword_t addr, mem_size_t size, logic sign);
        next_item();
        alu_out     = addr;
        load_size   = size;
        load_signed = sign;
        expect_data(expect_load(addr, size, sign));
    endtask

    task automatic cp0_write(cp0_num_t num, dword_t value);
        next_item();
        mtc0    = 1'b1;
        cp0_num = num;
        b_data  = value;
    endtask

    task automatic cp0_read(cp0_num_t num, dword_t value);
        next_item();
        mfc0    = 1'b1;
        cp0_num = num;
        expect_data(value);
    endtask

    task automatic irq_item(irq_t value, logic taken, output dword_t where);
        where = rand_dword();
        next_item();
        irq       = value;
        pc        = where;
        exp_taken = taken;
    endtask

    // Entry, cause readback with EPC, then return
    task automatic exception_item(logic ov, logic ri, logic sys, logic [4:0] code);
        dword_t where;
        where = rand_dword();
        next_item();
        pc            = where;
        overflow      = ov;
        reserved_inst = ri;
        syscall       = sys;
        exp_taken     = 1'b1;
        cp0_read(CP0_CAUSE, 64'(code) << CAUSE_CODE_LSB);
        exp_epc = where;
        chk_epc = 1'b1;
        next_item();
        eret = 1'b1;
    endtask

    initial begin : stimulus
        dword_t addr;
        dword_t where;
        dword_t value;
        int     prop_errors;
        seed       = 32'ha747;
        mem_filled = 1'b0;
        reset      = 1'b0;
        idle_inputs();
        #1 reset = 1'b1;  // Edge after time zero
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Give the test window known contents
        for (int a = 0; a < region_bytes; a += 8) begin
            store_item(64'(a), rand_dword(), SIZE_DWORD, 1'b0, 1'b0);
        end
        mem_filled = 1'b1;

        // Every store size followed by every load size, both extensions
        for (int round = 0; round < 3; round++) begin
            for (int s = 1; s <= 4; s++) begin
                addr = rand_addr();
                store_item(addr, rand_dword(), mem_size_t'(s), 1'b0, 1'b0);
                for (int l = 1; l <= 4; l++) begin
                    load_item(addr, mem_size_t'(l), 1'b0);
                    load_item(addr, mem_size_t'(l), 1'b1);
                end
            end
        end

        // Flushed and MMIO stores leave memory alone
        addr = rand_addr();
        store_item(addr, rand_dword(), SIZE_DWORD, 1'b1, 1'b0);
        load_item(addr, SIZE_DWORD, 1'b0);
        store_item(addr, rand_dword(), SIZE_DWORD, 1'b0, 1'b1);
        load_item(addr, SIZE_DWORD, 1'b0);
        next_item();
        alu_out     = addr;
        load_size   = SIZE_WORD;
        load_signed = 1'b1;
        d_valid     = 1'b1;
        expect_data(d_rdata);  // MMIO load

        exception_item(1'b1, 1'b0, 1'b0, EXC_OV);
        exception_item(1'b0, 1'b1, 1'b0, EXC_RI);
        exception_item(1'b0, 1'b0, 1'b1, EXC_SYS);
        exception_item(1'b1, 1'b1, 1'b1, EXC_OV);

        // Interrupt enable and mask
        cp0_write(CP0_STATUS, 64'h02 << STATUS_IM_LSB);
        irq_item(8'h02, 1'b0, where);  // Mask set but ie low
        cp0_write(CP0_STATUS, (64'h02 << STATUS_IM_LSB) | (64'h1 << STATUS_IE_BIT));
        irq_item(8'h01, 1'b0, where);
        irq_item(8'h02, 1'b1, where);
        cp0_read(CP0_CAUSE, (64'h02 << CAUSE_IP_LSB) | (64'(EXC_INT) << CAUSE_CODE_LSB));
        exp_epc = where;
        chk_epc = 1'b1;
        irq_item(8'h02, 1'b0, value);  // Still in the handler
        next_item();
        eret = 1'b1;
        irq_item(8'h02, 1'b1, where);
        cp0_read(CP0_EPC, where);
        next_item();
        eret = 1'b1;
        value = rand_dword();
        cp0_write(CP0_EPC, value);
        cp0_read(CP0_EPC, value);
        exp_epc = value;
        chk_epc = 1'b1;

        // Write-back priority and plain ALU results
        repeat (4) begin
            next_item();
            link_pc   = 1'b1;
            pc4       = rand_dword();
            mfc0      = 1'b1;
            load_size = SIZE_DWORD;
            expect_data(pc4);
            next_item();
            alu_out = rand_dword();
            expect_data(alu_out);
        end

        next_item();
        repeat (2) @(posedge clock);
        @(negedge clock);
        prop_errors = core_mem_stage_i.core_mem_properties_i.failures;
        $display("Errors: %0d in checks, %0d in bound properties", errors, prop_errors);
        if (errors == 0 && prop_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* sim/core_mem_properties.sv */
`timescale 1ns/1ns

module core_mem_properties (
    input logic                 clock,
    input logic                 reset,
    input logic                 d_valid,
    input core_pkg::mem_size_t  mem_load_size,
    input core_pkg::mem_size_t  mem_store_size,
    input core_pkg::dword_t     pc,
    input core_pkg::dword_t     epc_q,
    input logic                 write_enable_q,
    input logic                 taken_handler_q
);
    import core_pkg::*;

    int failures = 0;

    // Stage outputs stay quiet under reset
    idle_in_reset: assert property (
        @(posedge clock) reset |-> !write_enable_q && !taken_handler_q
    ) else begin
        failures++;
        $error("write_enable_q or taken_handler_q active while reset is high");
    end

    idle_after_reset: assert property (
        @(posedge clock) $fell(reset) |-> !write_enable_q && !taken_handler_q
    ) else begin
        failures++;
        $error("write_enable_q or taken_handler_q active in the first cycle after reset");
    end

    // MMIO accesses never reach the local memory
    mmio_no_store: assert property (
        @(posedge clock) disable iff (reset) d_valid |-> mem_store_size == SIZE_NONE
    ) else begin
        failures++;
        $error("local memory store size nonzero during an MMIO access");
    end

    mmio_no_load: assert property (
        @(posedge clock) disable iff (reset) d_valid |-> mem_load_size == SIZE_NONE
    ) else begin
        failures++;
        $error("local memory load size nonzero during an MMIO access");
    end

    // EPC register lands in epc_q one edge after taken_handler_q
    epc_after_handler: assert property (
        @(posedge clock) disable iff (reset) taken_handler_q |=> epc_q == $past(pc, 2)
    ) else begin
        failures++;
        $error("epc_q does not hold the pc of the instruction that entered the handler");
    end

endmodule

bind core_mem_stage core_mem_properties core_mem_properties_i (
    .clock           (clock),
    .reset           (reset),
    .d_valid         (d_valid),
    .mem_load_size   (mem_load_size),
    .mem_store_size  (mem_store_size),
    .pc              (pc),
    .epc_q           (epc_q),
    .write_enable_q  (write_enable_q),
    .taken_handler_q (taken_handler_q)
);

/* rtl/core_mem_stage.sv */
`timescale 1ns/1ns

module core_mem_stage #(
    parameter int mem_bytes = 4096
) (
    input  logic                 clock,
    input  logic                 reset,

    // From execute
    input  core_pkg::dword_t     alu_out,
    input  core_pkg::dword_t     b_data,
    input  core_pkg::mem_size_t  load_size,
    input  core_pkg::mem_size_t  store_size,
    input  logic                 load_signed,
    input  core_pkg::regnum_t    w_regnum,
    input  logic                 write_enable,
    input  logic                 mfc0,
    input  logic                 mtc0,
    input  core_pkg::cp0_num_t   cp0_num,
    input  logic                 link_pc,
    input  core_pkg::dword_t     pc,
    input  core_pkg::dword_t     pc4,
    input  logic                 overflow,
    input  logic                 reserved_inst,
    input  logic                 syscall,

    input  logic                 eret,     // From decode
    input  logic                 flush,
    input  core_pkg::dword_t     fetch_pc,
    input  core_pkg::irq_t       irq,
    input  logic                 d_valid,  // External port owns this access
    input  core_pkg::dword_t     d_rdata,

    output core_pkg::word_t      inst,
    output core_pkg::dword_t     w_data_q,
    output core_pkg::regnum_t    w_regnum_q,
    output logic                 write_enable_q,
    output core_pkg::dword_t     epc_q,
    output logic                 taken_handler_q
);
    import core_pkg::*;

    mem_size_t  mem_load_size;
    mem_size_t  mem_store_size;
    dword_t     mem_rdata;
    dword_t     cp0_rd_data;
    dword_t     epc;
    logic       taken_handler;
    dword_t     w_data;

    // MMIO accesses never touch local memory
    assign mem_load_size  = d_valid ? SIZE_NONE : load_size;
    assign mem_store_size = d_valid ? SIZE_NONE : store_size;

    data_mem #(
        .mem_bytes(mem_bytes)
    ) data_mem_i (
        .clock       (clock),
        .reset       (reset),
        .addr        (alu_out),
        .wdata       (b_data),
        .load_size   (mem_load_size),
        .store_size  (mem_store_size),
        .load_signed (load_signed),
        .flush       (flush),
        .inst_addr   (fetch_pc),
        .rdata       (mem_rdata),
        .inst        (inst)
    );

    cp0_regs cp0_regs_i (
        .clock         (clock),
        .reset         (reset),
        .wr_data       (b_data),
        .cp0_num       (cp0_num),
        .mtc0          (mtc0),
        .eret          (eret),
        .curr_pc       (pc),
        .irq           (irq),
        .overflow      (overflow),
        .reserved_inst (reserved_inst),
        .syscall       (syscall),
        .rd_data       (cp0_rd_data),
        .epc           (epc),
        .taken_handler (taken_handler)
    );

    // Write-back value
    always_comb begin
        if (link_pc)
            w_data = pc4;
        else if (mfc0)
            w_data = cp0_rd_data;
        else if (d_valid && load_size != SIZE_NONE)
            w_data = d_rdata;        // MMIO load
        else if (load_size != SIZE_NONE)
            w_data = mem_rdata;
        else
            w_data = alu_out;
    end

    // Stage register toward write-back
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            w_data_q        <= '0;
            w_regnum_q      <= '0;
            write_enable_q  <= 1'b0;
            epc_q           <= '0;
            taken_handler_q <= 1'b0;
        end else begin
            w_data_q        <= w_data;
            w_regnum_q      <= w_regnum;
            write_enable_q  <= write_enable;
            epc_q           <= epc;
            taken_handler_q <= taken_handler;
        end
    end

endmodule

/* rtl/cp0_regs.sv */
`timescale 1ns/1ns

module cp0_regs (
    input  logic                 clock,
    input  logic                 reset,
    input  core_pkg::dword_t     wr_data,
    input  core_pkg::cp0_num_t   cp0_num,
    input  logic                 mtc0,
    input  logic                 eret,
    input  core_pkg::dword_t     curr_pc,
    input  core_pkg::irq_t       irq,
    input  logic                 overflow,
    input  logic                 reserved_inst,
    input  logic                 syscall,
    output core_pkg::dword_t     rd_data,
    output core_pkg::dword_t     epc,
    output logic                 taken_handler
);
    import core_pkg::*;

    // Status fields
    logic       status_ie;
    logic       status_exl;
    irq_t       status_im;

    // Cause fields
    logic [4:0] cause_code;
    irq_t       cause_ip;

    dword_t     epc_r;
    dword_t     status_word;
    dword_t     cause_word;

    logic       exception;
    logic       int_pending;
    logic [4:0] next_code;

    assign exception   = overflow | reserved_inst | syscall;

    // Interrupts only while enabled and not already in the handler
    assign int_pending = (|(irq & status_im)) && status_ie && !status_exl;

    assign taken_handler = exception | int_pending;

    // Exception code, interrupt lowest
    always_comb begin
        if (overflow)
            next_code = EXC_OV;
        else if (reserved_inst)
            next_code = EXC_RI;
        else if (syscall)
            next_code = EXC_SYS;
        else
            next_code = EXC_INT;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            status_ie  <= 1'b0;
            status_exl <= 1'b0;
            status_im  <= '0;
            cause_code <= '0;
            cause_ip   <= '0;
            epc_r      <= '0;
        end else if (taken_handler) begin
            // Handler entry wins over mtc0 and eret
            epc_r      <= curr_pc;
            status_exl <= 1'b1;
            cause_code <= next_code;
            cause_ip   <= irq;
        end else begin
            if (mtc0) begin
                case (cp0_num)
                    CP0_STATUS: begin
                        status_ie  <= wr_data[STATUS_IE_BIT];
                        status_exl <= wr_data[STATUS_EXL_BIT];
                        status_im  <= wr_data[STATUS_IM_LSB +: 8];
                    end
                    CP0_CAUSE: begin
                        cause_code <= wr_data[CAUSE_CODE_LSB +: 5];
                        cause_ip   <= wr_data[CAUSE_IP_LSB +: 8];
                    end
                    CP0_EPC: epc_r <= wr_data;
                    default: ; // Unknown registers ignore writes
                endcase
            end
            if (eret) begin
                status_exl <= 1'b0; // Back to user level
            end
        end
    end

    // Register images as seen by mfc0
    always_comb begin
        status_word = '0;
        status_word[STATUS_IE_BIT]       = status_ie;
        status_word[STATUS_EXL_BIT]      = status_exl;
        status_word[STATUS_IM_LSB +: 8]  = status_im;
    end

    always_comb begin
        cause_word = '0;
        cause_word[CAUSE_CODE_LSB +: 5] = cause_code;
        cause_word[CAUSE_IP_LSB +: 8]   = cause_ip;
    end

    always_comb begin
        case (cp0_num)
            CP0_STATUS: rd_data = status_word;
            CP0_CAUSE:  rd_data = cause_word;
            CP0_EPC:    rd_data = epc_r;
            default:    rd_data = '0;
        endcase
    end

    assign epc = epc_r;

endmodule

/* rtl/data_mem.sv */
`timescale 1ns/1ns

module data_mem #(
    parameter int mem_bytes = 4096
) (
    input  logic                 clock,
    input  logic                 reset,
    input  core_pkg::dword_t     addr,
    input  core_pkg::dword_t     wdata,
    input  core_pkg::mem_size_t  load_size,
    input  core_pkg::mem_size_t  store_size,
    input  logic                 load_signed,
    input  logic                 flush,
    input  core_pkg::dword_t     inst_addr,
    output core_pkg::dword_t     rdata,
    output core_pkg::word_t      inst
);
    import core_pkg::*;

    localparam int addr_bits = $clog2(mem_bytes);
    localparam int line_bits = addr_bits - 3; // Doubleword lines

    logic [7:0] mem [mem_bytes]; // No reset, contents undefined at start

    logic [line_bits-1:0]   line_idx;
    logic [2:0]             offset;
    logic [addr_bits-3:0]   inst_idx;
    dword_t                 line_data;
    dword_t                 lane_data;
    dword_t                 store_lanes;
    logic [7:0]             byte_en;

    assign line_idx = addr[addr_bits-1:3];
    assign offset   = addr[2:0];
    assign inst_idx = inst_addr[addr_bits-1:2];

    // Whole doubleword around the access, little-endian
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            line_data[8*i +: 8] = mem[{line_idx, 3'(i)}];
        end
    end

    // Move the addressed lane down to bit 0, aligned to its size
    always_comb begin
        case (load_size)
            SIZE_BYTE:  lane_data = line_data >> {offset, 3'b000};
            SIZE_HALF:  lane_data = line_data >> {offset[2:1], 4'b0000};
            SIZE_WORD:  lane_data = line_data >> {offset[2], 5'b00000};
            SIZE_DWORD: lane_data = line_data;
            default:    lane_data = '0;
        endcase
    end

    // Sign or zero extension
    always_comb begin
        case (load_size)
            SIZE_BYTE: begin
                if (load_signed)
                    rdata = {{56{lane_data[7]}}, lane_data[7:0]};
                else
                    rdata = {56'b0, lane_data[7:0]};
            end
            SIZE_HALF: begin
                if (load_signed)
                    rdata = {{48{lane_data[15]}}, lane_data[15:0]};
                else
                    rdata = {48'b0, lane_data[15:0]};
            end
            SIZE_WORD: begin
                if (load_signed)
                    rdata = {{32{lane_data[31]}}, lane_data[31:0]};
                else
                    rdata = {32'b0, lane_data[31:0]};
            end
            SIZE_DWORD: rdata = lane_data;
            default:    rdata = '0; // No load this cycle
        endcase
    end

    // Store data replicated across every lane of its size
    always_comb begin
        case (store_size)
            SIZE_BYTE:  store_lanes = {8{wdata[7:0]}};
            SIZE_HALF:  store_lanes = {4{wdata[15:0]}};
            SIZE_WORD:  store_lanes = {2{wdata[31:0]}};
            default:    store_lanes = wdata;
        endcase
    end

    // Byte enables for the addressed lane
    always_comb begin
        case (store_size)
            SIZE_BYTE:  byte_en = 8'b0000_0001 << offset;
            SIZE_HALF:  byte_en = 8'b0000_0011 << {offset[2:1], 1'b0};
            SIZE_WORD:  byte_en = 8'b0000_1111 << {offset[2], 2'b00};
            SIZE_DWORD: byte_en = 8'b1111_1111;
            default:    byte_en = 8'b0000_0000;
        endcase
    end

    // A flushed store is dropped, and nothing is written while in reset
    always_ff @(posedge clock) begin
        if (!reset && !flush) begin
            for (int i = 0; i < 8; i++) begin
                if (byte_en[i]) begin
                    mem[{line_idx, 3'(i)}] <= store_lanes[8*i +: 8];
                end
            end
        end
    end

    // Instruction port, word aligned
    assign inst = {mem[{inst_idx, 2'd3}],
                   mem[{inst_idx, 2'd2}],
                   mem[{inst_idx, 2'd1}],
                   mem[{inst_idx, 2'd0}]};

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

    // Datapath widths
    typedef logic [63:0] dword_t;    // Data or address
    typedef logic [31:0] word_t;     // Instruction word
    typedef logic [4:0]  regnum_t;   // General register number
    typedef logic [4:0]  cp0_num_t;  // Coprocessor-0 register number
    typedef logic [2:0]  mem_size_t; // Access size, zero means no access
    typedef logic [7:0]  irq_t;      // Interrupt sources

    // Load and store sizes
    localparam mem_size_t SIZE_NONE  = 3'd0;
    localparam mem_size_t SIZE_BYTE  = 3'd1;
    localparam mem_size_t SIZE_HALF  = 3'd2;
    localparam mem_size_t SIZE_WORD  = 3'd3;
    localparam mem_size_t SIZE_DWORD = 3'd4;

    // Coprocessor-0 register numbers
    localparam cp0_num_t CP0_STATUS = 5'd12;
    localparam cp0_num_t CP0_CAUSE  = 5'd13;
    localparam cp0_num_t CP0_EPC    = 5'd14;

    // Exception codes as recorded in cause
    localparam logic [4:0] EXC_INT = 5'd0;  // Interrupt
    localparam logic [4:0] EXC_SYS = 5'd8;  // Syscall
    localparam logic [4:0] EXC_RI  = 5'd10; // Reserved instruction
    localparam logic [4:0] EXC_OV  = 5'd12; // Overflow

    // Field positions inside status
    localparam int STATUS_IE_BIT  = 0;
    localparam int STATUS_EXL_BIT = 1;
    localparam int STATUS_IM_LSB  = 8;

    // Field positions inside cause
    localparam int CAUSE_CODE_LSB = 2;
    localparam int CAUSE_IP_LSB   = 8;

endpackage
